// ==== common/gf8_pkg.sv ====
package gf8_pkg;

  localparam int GF8_W = 3;

  // GF(2^3) in polynomial basis {1, t, t^2}, reduced by t^3 = t^2 + 1.
  typedef logic [GF8_W-1:0] gf8_t;

  // Composite element lo*beta + hi*beta^8 over the normal basis of GF((2^3)^2).
  // beta + beta^8 = t and beta * beta^8 = t^6.
  typedef struct packed {
    gf8_t hi;
    gf8_t lo;
  } gf64_t;

  localparam gf8_t GF8_ZERO = 3'b000;
  localparam gf8_t GF8_ONE  = 3'b001;

  // Constant index 6 selects t^5, the beta^8 coefficient of beta^2.
  localparam logic [2:0] GF8_CK_BETA = 3'd6;

  function automatic gf8_t gf8_add(gf8_t a, gf8_t b);
    return a ^ b;
  endfunction

  function automatic gf8_t gf8_mul(gf8_t a, gf8_t b);
    logic [4:0] p;
    gf8_t       c;
    p[0] = a[0] & b[0];
    p[1] = (a[0] & b[1]) ^ (a[1] & b[0]);
    p[2] = (a[0] & b[2]) ^ (a[1] & b[1]) ^ (a[2] & b[0]);
    p[3] = (a[1] & b[2]) ^ (a[2] & b[1]);
    p[4] = a[2] & b[2];
    // Fold t^3 = t^2 + 1 and t^4 = t^2 + t + 1 back into the basis.
    c[0] = p[0] ^ p[3] ^ p[4];
    c[1] = p[1] ^ p[4];
    c[2] = p[2] ^ p[3] ^ p[4];
    return c;
  endfunction

  function automatic gf8_t gf8_sq(gf8_t a);
    return {a[1] ^ a[2], a[2], a[0] ^ a[2]};
  endfunction

  function automatic gf8_t gf8_cube(gf8_t a);
    return gf8_mul(gf8_sq(a), a);
  endfunction

  // Index 0 is the zero multiplier, index k > 0 multiplies by t^(k-1).
  function automatic gf8_t gf8_cmul(gf8_t a, logic [2:0] k);
    gf8_t c;
    case (k)
      3'd0:    c = GF8_ZERO;
      3'd1:    c = GF8_ONE;
      3'd2:    c = 3'b010;
      3'd3:    c = 3'b100;
      3'd4:    c = 3'b101;
      3'd5:    c = 3'b111;
      3'd6:    c = 3'b011;
      default: c = 3'b110;
    endcase
    return gf8_mul(a, c);
  endfunction

endpackage

// ==== common/sbox_pkg.sv ====
package sbox_pkg;

  // Each lane carries one GF(2^6) symbol.
  localparam int SYM_W = 6;

  localparam int NUM_LANES = 4;

  localparam int WORD_W = SYM_W * NUM_LANES;

  // Basis in, power, basis out, one register each.
  localparam int PIPE_LAT = 3;

  // Forward raises every symbol to the power 10, inverse to the power 19.
  // 10 * 19 = 190 = 1 mod 63, so one undoes the other.
  typedef enum logic {
    OP_FWD = 1'b0,
    OP_INV = 1'b1
  } sbox_op_e;

endpackage

// ==== power_map/tower_basis_in.sv ====
`timescale 1ns/1ps

// Column k of the matrix is alpha^k written in the composite basis, with
// alpha = beta. Symbol bit 0 is therefore the field one, which lands on
// lo = hi = t^6.
module tower_basis_in
  import gf8_pkg::*;
(
  input  logic [5:0] sym,
  output gf64_t      comp
);

  logic [5:0] b;

  assign b[0] = sym[1] ^ sym[2] ^ sym[4];
  assign b[1] = sym[0] ^ sym[4];
  assign b[2] = sym[0] ^ sym[3] ^ sym[5];
  assign b[3] = sym[2];
  assign b[4] = sym[0] ^ sym[2] ^ sym[3] ^ sym[4] ^ sym[5];
  assign b[5] = sym[0] ^ sym[3] ^ sym[4];

  assign comp = gf64_t'(b);

endmodule

// ==== power_map/tower_basis_out.sv ====
`timescale 1ns/1ps

// Inverse of the tower_basis_in matrix over GF(2).
module tower_basis_out
  import gf8_pkg::*;
(
  input  gf64_t      comp,
  output logic [5:0] sym
);

  logic [5:0] b;

  assign b = comp;

  assign sym[0] = b[1] ^ b[2] ^ b[3] ^ b[4];
  assign sym[1] = b[0] ^ b[2] ^ b[4];
  assign sym[2] = b[3];
  assign sym[3] = b[1] ^ b[5];
  assign sym[4] = b[2] ^ b[3] ^ b[4];
  assign sym[5] = b[3] ^ b[4] ^ b[5];

endmodule

// ==== power_map/tower_power.sv ====
`timescale 1ns/1ps

module tower_power
  import gf8_pkg::*, sbox_pkg::*;
(
  input  gf64_t    comp_in,
  input  sbox_op_e op,
  output gf64_t    comp_out
);

  // With beta^2 = beta + t^5*beta^8, squaring mixes the two halves.
  function automatic gf64_t gf64_sq(gf64_t x);
    gf8_t  lo2;
    gf8_t  hi2;
    gf64_t r;
    lo2  = gf8_sq(x.lo);
    hi2  = gf8_sq(x.hi);
    r.lo = gf8_add(lo2, gf8_cmul(hi2, GF8_CK_BETA));
    r.hi = gf8_add(hi2, gf8_cmul(lo2, GF8_CK_BETA));
    return r;
  endfunction

  // The cross term lands on beta^9 = t^6 = t^5*(beta + beta^8).
  function automatic gf64_t gf64_mul(gf64_t a, gf64_t b);
    gf8_t  ll;
    gf8_t  hh;
    gf8_t  cr;
    gf64_t r;
    ll   = gf8_mul(a.lo, b.lo);
    hh   = gf8_mul(a.hi, b.hi);
    cr   = gf8_add(gf8_mul(a.lo, b.hi), gf8_mul(a.hi, b.lo));
    r.lo = gf8_add(ll, gf8_cmul(gf8_add(hh, cr), GF8_CK_BETA));
    r.hi = gf8_add(hh, gf8_cmul(gf8_add(ll, cr), GF8_CK_BETA));
    return r;
  endfunction

  gf8_t  lo_sq;
  gf8_t  hi_sq;
  gf8_t  y0;
  gf8_t  y1;
  gf8_t  y2;
  gf8_t  y3;
  gf64_t p10;

  gf64_t x2;
  gf64_t x3;
  gf64_t x4;
  gf64_t x8;
  gf64_t x16;
  gf64_t p19;

  // x^10 is the norm x^9 times x, so both halves share one cubic form.
  assign lo_sq = gf8_sq(comp_in.lo);
  assign hi_sq = gf8_sq(comp_in.hi);
  assign y0    = gf8_cube(comp_in.lo);
  assign y3    = gf8_cube(comp_in.hi);
  assign y1    = gf8_mul(comp_in.lo, hi_sq);
  assign y2    = gf8_mul(comp_in.hi, lo_sq);

  assign p10.lo = gf8_add(gf8_add(gf8_cmul(y0, 3'd7), gf8_cmul(y1, 3'd7)),
                          gf8_add(gf8_cmul(y2, 3'd3), gf8_cmul(y3, 3'd0)));
  assign p10.hi = gf8_add(gf8_add(gf8_cmul(y0, 3'd0), gf8_cmul(y1, 3'd3)),
                          gf8_add(gf8_cmul(y2, 3'd7), gf8_cmul(y3, 3'd7)));

  // x^19 = x^16 * x^3.
  assign x2  = gf64_sq(comp_in);
  assign x4  = gf64_sq(x2);
  assign x8  = gf64_sq(x4);
  assign x16 = gf64_sq(x8);
  assign x3  = gf64_mul(x2, comp_in);
  assign p19 = gf64_mul(x16, x3);

  assign comp_out = (op == OP_INV) ? p19 : p10;

endmodule

// ==== power_map/sbox_lane.sv ====
`timescale 1ns/1ps

// One symbol through basis change, power map and basis change back.
// The data registers run every cycle; valid is tracked in sbox_layer.
module sbox_lane
  import gf8_pkg::*, sbox_pkg::*;
(
  input  logic             clk,
  input  logic [SYM_W-1:0] in_sym,
  input  sbox_op_e         op_s1,
  output logic [SYM_W-1:0] out_sym
);

  gf64_t            comp_d;
  gf64_t            comp_s1;
  gf64_t            pow_d;
  gf64_t            pow_s2;
  logic [SYM_W-1:0] sym_d;

  tower_basis_in basis_in_inst (
    .sym  (in_sym),
    .comp (comp_d)
  );

  // Stage 1.
  always_ff @(posedge clk) begin
    comp_s1 <= comp_d;
  end

  // op_s1 belongs to the word now held in comp_s1.
  tower_power power_inst (
    .comp_in  (comp_s1),
    .op       (op_s1),
    .comp_out (pow_d)
  );

  // Stage 2.
  always_ff @(posedge clk) begin
    pow_s2 <= pow_d;
  end

  tower_basis_out basis_out_inst (
    .comp (pow_s2),
    .sym  (sym_d)
  );

  // Stage 3 drives the lane output directly.
  always_ff @(posedge clk) begin
    out_sym <= sym_d;
  end

endmodule

// ==== hdl/sbox_layer.sv ====
`timescale 1ns/1ps

module sbox_layer
  import sbox_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  sbox_op_e          in_op,
  input  logic [WORD_W-1:0] in_word,
  output logic              out_valid,
  output sbox_op_e          out_op,
  output logic [WORD_W-1:0] out_word
);

  logic [PIPE_LAT-1:0] valid_pipe;
  sbox_op_e            op_pipe [PIPE_LAT];

  // Valid shift register, one bit per stage.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_LAT-2:0], in_valid};
    end
  end

  // Opcode travels alongside the lane data, one entry per stage.
  always_ff @(posedge clk) begin
    op_pipe[0] <= in_op;
    for (int i = 1; i < PIPE_LAT; i++) begin
      op_pipe[i] <= op_pipe[i-1];
    end
  end

  assign out_valid = valid_pipe[PIPE_LAT-1];
  assign out_op    = op_pipe[PIPE_LAT-1];

  // Every lane sees the same opcode. The power stage needs the one
  // captured together with stage 1 data.
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    sbox_lane lane_inst (
      .clk     (clk),
      .in_sym  (in_word[k*SYM_W +: SYM_W]),
      .op_s1   (op_pipe[0]),
      .out_sym (out_word[k*SYM_W +: SYM_W])
    );
  end

endmodule

// ==== testbench/sbox_layer_asserts.sv ====
`timescale 1ns/1ps

// Bound into sbox_layer. Every check looks back PIPE_LAT cycles to the
// word that was accepted at the input.
module sbox_layer_asserts
  import sbox_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              in_valid,
  input sbox_op_e          in_op,
  input logic [WORD_W-1:0] in_word,
  input logic              out_valid,
  input sbox_op_e          out_op,
  input logic [WORD_W-1:0] out_word
);

  int fail_count = 0;

  // True when every symbol of the word is 0 or 1.
  function automatic logic only_zero_one(logic [WORD_W-1:0] w);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (w[k*SYM_W+1 +: SYM_W-1] != '0) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  function automatic logic all_lanes_equal(logic [WORD_W-1:0] w);
    logic same;
    same = 1'b1;
    for (int k = 1; k < NUM_LANES; k++) begin
      if (w[k*SYM_W +: SYM_W] != w[SYM_W-1:0]) begin
        same = 1'b0;
      end
    end
    return same;
  endfunction

  a_reset_clears_valid: assert property (@(posedge clk) $past(rst) |-> !out_valid)
    else begin
      $error("out_valid is high in the cycle after reset");
      fail_count++;
    end

  a_valid_latency: assert property (@(posedge clk) disable iff (rst)
    $past(in_valid, PIPE_LAT) |-> out_valid)
    else begin
      $error("out_valid missing %0d cycles after in_valid", PIPE_LAT);
      fail_count++;
    end

  a_no_spurious_valid: assert property (@(posedge clk) disable iff (rst)
    !$past(in_valid, PIPE_LAT) |-> !out_valid)
    else begin
      $error("out_valid high without a word accepted %0d cycles before", PIPE_LAT);
      fail_count++;
    end

  a_op_follows_word: assert property (@(posedge clk) disable iff (rst)
    $past(in_valid, PIPE_LAT) |-> (out_op == $past(in_op, PIPE_LAT)))
    else begin
      $error("out_op does not match the opcode of its word");
      fail_count++;
    end

  // Any power map leaves 0 and 1 where they are.
  a_fixed_points: assert property (@(posedge clk) disable iff (rst)
    ($past(in_valid, PIPE_LAT) && only_zero_one($past(in_word, PIPE_LAT)))
    |-> (out_word == $past(in_word, PIPE_LAT)))
    else begin
      $error("symbols 0 and 1 were not mapped to themselves");
      fail_count++;
    end

  a_lane_independence: assert property (@(posedge clk) disable iff (rst)
    ($past(in_valid, PIPE_LAT) && all_lanes_equal($past(in_word, PIPE_LAT)))
    |-> all_lanes_equal(out_word))
    else begin
      $error("identical input symbols gave different output symbols");
      fail_count++;
    end

endmodule

bind sbox_layer sbox_layer_asserts asserts_inst (.*);

// ==== testbench/tb_sbox_layer.sv ====
`timescale 1ns/1ps

module tb_sbox_layer
  import sbox_pkg::*;
();

  localparam int N_BURST  = 8;
  localparam int N_GAPPED = 4;
  localparam int GAP      = 2;
  localparam int N_FIXED  = 32;
  localparam int N_RT     = 32;
  localparam int N_SYMS   = 1 << SYM_W;
  localparam int N_SWEEP  = 2 * N_SYMS;

  // Reset plus every driven cycle, then a margin for each drain.
  localparam int NUM_SLOTS  = 2 + N_BURST + N_GAPPED * (GAP + 1) + N_FIXED + 2 * N_RT + N_SWEEP;
  localparam int NUM_DRAINS = 4;
  localparam int WATCHDOG_CYCLES = NUM_SLOTS + NUM_DRAINS * (PIPE_LAT + 2) + PIPE_LAT + 20;

  logic              clk;
  logic              rst;
  logic              in_valid;
  sbox_op_e          in_op;
  logic [WORD_W-1:0] in_word;
  logic              out_valid;
  sbox_op_e          out_op;
  logic [WORD_W-1:0] out_word;

  int seed = 32'h6ce49ad2;
  int err_count = 0;

  sbox_op_e          sent_op_q [$];
  logic [WORD_W-1:0] out_word_q [$];

  logic [WORD_W-1:0] rt_orig [N_RT];
  logic [WORD_W-1:0] rt_fwd [N_RT];

  sbox_layer sbox_layer_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_word   (in_word),
    .out_valid (out_valid),
    .out_op    (out_op),
    .out_word  (out_word)
  );

  always #5 clk = ~clk;

  task automatic drive_word(input sbox_op_e op, input logic [WORD_W-1:0] word);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_op    = op;
    in_word  = word;
    sent_op_q.push_back(op);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    drive_idle();
    while (sent_op_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Outputs settle after the rising edge, so the falling edge is safe.
  always @(negedge clk) begin
    sbox_op_e exp_op;
    if (!rst && out_valid) begin
      if (sent_op_q.size() == 0) begin
        $display("Error: output word %h appeared with no word in flight", out_word);
        err_count++;
      end else begin
        exp_op = sent_op_q.pop_front();
        if (out_op !== exp_op) begin
          $display("Fail output_op: expected %0d, actual %0d", exp_op, out_op);
          err_count++;
        end
        out_word_q.push_back(out_word);
      end
    end
  end

  initial begin
    logic [31:0]       rnd;
    logic [WORD_W-1:0] w;
    logic [N_SYMS-1:0] seen;
    logic [SYM_W-1:0]  s;
    int                dup;
    int                assert_fails;
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_op    = OP_FWD;
    in_word  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Back-to-back words, then words with idle cycles between them.
    for (int i = 0; i < N_BURST; i++) begin
      rnd = $random(seed);
      drive_word(sbox_op_e'(rnd[WORD_W]), rnd[WORD_W-1:0]);
    end
    for (int i = 0; i < N_GAPPED; i++) begin
      rnd = $random(seed);
      drive_word(sbox_op_e'(rnd[WORD_W]), rnd[WORD_W-1:0]);
      repeat (GAP) drive_idle();
    end

    // Every mix of 0 and 1 over the four lanes, under both opcodes.
    for (int op = 0; op < 2; op++) begin
      for (int m = 0; m < N_FIXED / 2; m++) begin
        w = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
          w[k*SYM_W] = m[k];
        end
        drive_word(sbox_op_e'(op[0]), w);
      end
    end
    wait_drained();
    out_word_q.delete();

    // Forward pass, then the forward results go back in as inverse.
    for (int i = 0; i < N_RT; i++) begin
      rnd = $random(seed);
      rt_orig[i] = rnd[WORD_W-1:0];
      drive_word(OP_FWD, rt_orig[i]);
    end
    wait_drained();
    if (out_word_q.size() != N_RT) begin
      $display("Fail round_trip_count: expected %0d, actual %0d", N_RT, out_word_q.size());
      err_count++;
    end
    for (int i = 0; i < N_RT; i++) begin
      rt_fwd[i] = out_word_q[i];
    end
    out_word_q.delete();
    for (int i = 0; i < N_RT; i++) begin
      drive_word(OP_INV, rt_fwd[i]);
    end
    wait_drained();
    for (int i = 0; i < N_RT; i++) begin
      if (out_word_q[i] !== rt_orig[i]) begin
        $display("Fail round_trip[%0d]: expected %h, actual %h", i, rt_orig[i], out_word_q[i]);
        err_count++;
      end
    end
    out_word_q.delete();

    // Sweep of all symbols, repeated over the lanes.
    for (int op = 0; op < 2; op++) begin
      for (int v = 0; v < N_SYMS; v++) begin
        drive_word(sbox_op_e'(op[0]), {NUM_LANES{v[SYM_W-1:0]}});
      end
    end
    wait_drained();
    if (out_word_q.size() != N_SWEEP) begin
      $display("Fail sweep_count: expected %0d, actual %0d", N_SWEEP, out_word_q.size());
      err_count++;
    end
    for (int h = 0; h < 2; h++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        seen = '0;
        dup  = 0;
        for (int i = 0; i < N_SYMS; i++) begin
          s = out_word_q[h*N_SYMS + i][k*SYM_W +: SYM_W];
          if (seen[s]) begin
            dup++;
          end
          seen[s] = 1'b1;
        end
        if (dup != 0) begin
          $display("Fail permutation_%s lane %0d: expected %0d distinct, actual %0d",
                   (h == 0) ? "fwd" : "inv", k, N_SYMS, N_SYMS - dup);
          err_count++;
        end
      end
    end

    assert_fails = sbox_layer_inst.asserts_inst.fail_count;
    $display("Errors: scoreboard %0d, assertions %0d", err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sbox_layer.f ====
common/gf8_pkg.sv
common/sbox_pkg.sv
power_map/tower_basis_in.sv
power_map/tower_basis_out.sv
power_map/tower_power.sv
power_map/sbox_lane.sv
hdl/sbox_layer.sv
testbench/sbox_layer_asserts.sv
testbench/tb_sbox_layer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_sbox_layer
FILELIST  = sbox_layer.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
